// ==== tb.f ====
logic/mips_pkg.sv
logic/regf_if.sv
logic/regfile.sv
logic/decoder.sv
logic/alu.sv
logic/hazard_unit.sv
logic/datapath.sv
logic/cpu_top.sv
test/tb_mem.sv
test/tb_cpu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the pipeline testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_cpu -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_cpu > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$log"; then
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$log"; then
    echo "No result line found in $log"
    exit 1
fi
exit 0

// ==== test/tb_cpu.sv ====
`timescale 1ns/1ns

module tb_cpu import mips_pkg::*; ();

    localparam logic [5:0] OPC_BEQ   = 6'h04;
    localparam logic [5:0] OPC_BNE   = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09;
    localparam logic [5:0] OPC_ORI   = 6'h0d;
    localparam logic [5:0] OPC_LUI   = 6'h0f;
    localparam logic [5:0] OPC_LW    = 6'h23;
    localparam logic [5:0] OPC_SW    = 6'h2b;
    localparam logic [5:0] FN_ADDU   = 6'h21;
    localparam logic [5:0] FN_SUBU   = 6'h23;
    localparam logic [5:0] FN_AND    = 6'h24;
    localparam logic [5:0] FN_OR     = 6'h25;
    localparam logic [5:0] FN_SLT    = 6'h2a;

    localparam word_t RESET_PC = 32'h0;

    logic  clk = 1'b0;
    logic  rst_n = 1'b0;
    word_t imem_addr;
    word_t imem_data;
    logic  dmem_we;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    logic  wb_we;
    word_t wb_pc;
    regf_t wb_regf;
    word_t wb_data;

    word_t prog [$];
    word_t ram_seed [64];
    string exp_wb_name [$];
    word_t exp_wb_pc [$];
    regf_t exp_wb_regf [$];
    word_t exp_wb_data [$];
    string exp_st_name [$];
    word_t exp_st_addr [$];
    word_t exp_st_data [$];

    int    cycles = 0;
    int    cycle_limit = 1000;
    int    wb_seen = 0;
    int    st_seen = 0;

    cpu_top #(
        .RESET_PC (RESET_PC)
    ) i_dut (
        .clk          (clk       ),
        .rst_n_i      (rst_n     ),
        .imem_addr_o  (imem_addr ),
        .imem_data_i  (imem_data ),
        .dmem_we_o    (dmem_we   ),
        .dmem_addr_o  (dmem_addr ),
        .dmem_wdata_o (dmem_wdata),
        .dmem_rdata_i (dmem_rdata),
        .wb_we_o      (wb_we     ),
        .wb_pc_o      (wb_pc     ),
        .wb_regf_o    (wb_regf   ),
        .wb_data_o    (wb_data   )
    );

    tb_mem i_mem (
        .clk_i        (clk       ),
        .imem_addr_i  (imem_addr ),
        .imem_data_o  (imem_data ),
        .dmem_we_i    (dmem_we   ),
        .dmem_addr_i  (dmem_addr ),
        .dmem_wdata_i (dmem_wdata),
        .dmem_rdata_o (dmem_rdata)
    );

    always #20 clk = ~clk;

    function automatic word_t enc_r(input logic [5:0] funct, input regf_t rd,
                                    input regf_t rs, input regf_t rt);
        return {6'h00, rs, rt, rd, 5'h00, funct};
    endfunction

    function automatic word_t enc_i(input logic [5:0] op, input regf_t rt,
                                    input regf_t rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic build_program();
        prog.push_back(enc_i(OPC_ADDIU, 5'd1, 5'd0, 16'h0005));
        prog.push_back(enc_i(OPC_ADDIU, 5'd2, 5'd1, 16'h0003));    // Distance 1
        prog.push_back(enc_i(OPC_ADDIU, 5'd3, 5'd0, 16'hfffe));
        prog.push_back(enc_r(FN_SUBU, 5'd4, 5'd2, 5'd1));          // Distances 2 and 3
        prog.push_back(enc_r(FN_AND, 5'd5, 5'd4, 5'd3));
        prog.push_back(enc_r(FN_OR, 5'd6, 5'd5, 5'd1));
        prog.push_back(enc_r(FN_SLT, 5'd7, 5'd3, 5'd1));
        prog.push_back(enc_r(FN_SLT, 5'd8, 5'd1, 5'd3));
        prog.push_back(enc_i(OPC_ORI, 5'd9, 5'd1, 16'h8000));
        prog.push_back(enc_i(OPC_LUI, 5'd10, 5'd0, 16'h1234));
        prog.push_back(enc_i(OPC_ORI, 5'd10, 5'd10, 16'h5678));
        prog.push_back(enc_r(FN_ADDU, 5'd11, 5'd10, 5'd9));
        prog.push_back(enc_i(OPC_ADDIU, 5'd0, 5'd1, 16'h0007));    // Write to $0
        prog.push_back(enc_r(FN_ADDU, 5'd12, 5'd0, 5'd1));
        prog.push_back(enc_i(OPC_ADDIU, 5'd13, 5'd0, 16'h0020));   // Data base
        prog.push_back(enc_i(OPC_LW, 5'd14, 5'd13, 16'h0004));
        prog.push_back(enc_r(FN_ADDU, 5'd15, 5'd14, 5'd1));        // Load use
        prog.push_back(enc_i(OPC_LW, 5'd16, 5'd13, 16'h0008));
        prog.push_back(enc_i(OPC_ORI, 5'd17, 5'd0, 16'h00aa));
        prog.push_back(enc_r(FN_SUBU, 5'd18, 5'd16, 5'd17));
        prog.push_back(enc_i(OPC_SW, 5'd18, 5'd13, 16'h0010));
        prog.push_back(enc_i(OPC_LW, 5'd19, 5'd13, 16'h0010));
        prog.push_back(enc_i(OPC_BEQ, 5'd18, 5'd19, 16'h0002));    // Taken
        prog.push_back(enc_i(OPC_ADDIU, 5'd20, 5'd0, 16'h0011));
        prog.push_back(enc_i(OPC_ADDIU, 5'd21, 5'd0, 16'h0022));   // Skipped
        prog.push_back(enc_i(OPC_BNE, 5'd2, 5'd1, 16'h0002));      // Taken
        prog.push_back(enc_i(OPC_ADDIU, 5'd22, 5'd0, 16'h0033));
        prog.push_back(enc_i(OPC_ADDIU, 5'd23, 5'd0, 16'h0044));   // Skipped
        prog.push_back(enc_i(OPC_BEQ, 5'd2, 5'd1, 16'h0005));      // Not taken
        prog.push_back(enc_i(OPC_ADDIU, 5'd24, 5'd0, 16'h0055));
        prog.push_back(enc_i(OPC_ADDIU, 5'd25, 5'd24, 16'h0001));
        prog.push_back(enc_i(OPC_SW, 5'd25, 5'd13, 16'h0014));
        prog.push_back(enc_i(OPC_BEQ, 5'd0, 5'd0, 16'hffff));      // Branch to self
        prog.push_back(32'h0);
    endtask

    // Index is the producing instruction's slot in the program table
    task automatic add_wb(input string name, input int idx, input regf_t regf,
                          input word_t data);
        exp_wb_name.push_back(name);
        exp_wb_pc.push_back(RESET_PC + 32'(idx * 4));
        exp_wb_regf.push_back(regf);
        exp_wb_data.push_back(data);
    endtask

    task automatic add_store(input string name, input word_t addr, input word_t data);
        exp_st_name.push_back(name);
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(data);
    endtask

    task automatic build_expected();
        add_wb("addiu", 0, 5'd1, 32'h0000_0005);
        add_wb("fwd_ex_addiu", 1, 5'd2, 32'h0000_0008);
        add_wb("addiu_negative", 2, 5'd3, 32'hffff_fffe);
        add_wb("fwd_mm_wb_subu", 3, 5'd4, 32'h0000_0003);
        add_wb("and", 4, 5'd5, 32'h0000_0002);
        add_wb("or", 5, 5'd6, 32'h0000_0007);
        add_wb("slt_true", 6, 5'd7, 32'h0000_0001);
        add_wb("slt_false", 7, 5'd8, 32'h0000_0000);
        add_wb("ori_zero_ext", 8, 5'd9, 32'h0000_8005);
        add_wb("lui", 9, 5'd10, 32'h1234_0000);
        add_wb("ori_after_lui", 10, 5'd10, 32'h1234_5678);
        add_wb("addu", 11, 5'd11, 32'h1234_d67d);
        add_wb("read_r0", 13, 5'd12, 32'h0000_0005);
        add_wb("base", 14, 5'd13, 32'h0000_0020);
        add_wb("lw", 15, 5'd14, ram_seed[9]);
        add_wb("load_use", 16, 5'd15, ram_seed[9] + 32'd5);
        add_wb("lw_second", 17, 5'd16, ram_seed[10]);
        add_wb("ori", 18, 5'd17, 32'h0000_00aa);
        add_wb("load_fwd_wb", 19, 5'd18, ram_seed[10] - 32'h0000_00aa);
        add_store("sw_fwd_ex", 32'h0000_0030, ram_seed[10] - 32'h0000_00aa);
        add_wb("lw_after_sw", 21, 5'd19, ram_seed[10] - 32'h0000_00aa);
        add_wb("beq_delay_slot", 23, 5'd20, 32'h0000_0011);
        add_wb("bne_delay_slot", 26, 5'd22, 32'h0000_0033);
        add_wb("not_taken_slot", 29, 5'd24, 32'h0000_0055);
        add_wb("fall_through", 30, 5'd25, 32'h0000_0056);
        add_store("sw_after_branch", 32'h0000_0034, 32'h0000_0056);
    endtask

    task automatic check_wb(input string name, input word_t exp_pc, input regf_t exp_regf,
                            input word_t exp_data, input word_t act_pc,
                            input regf_t act_regf, input word_t act_data);
        if (act_pc !== exp_pc || act_regf !== exp_regf || act_data !== exp_data) begin
            $display("Error: %s expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
                     name, exp_pc, exp_regf, exp_data, act_pc, act_regf, act_data);
            $display("TEST RESULT: FAIL");
            $fatal(1, "write-back mismatch");
        end
    endtask

    task automatic check_store(input string name, input word_t exp_addr, input word_t exp_data,
                               input word_t act_addr, input word_t act_data);
        if (act_addr !== exp_addr || act_data !== exp_data) begin
            $display("Error: %s expected [%h]=%h, actual [%h]=%h",
                     name, exp_addr, exp_data, act_addr, act_data);
            $display("TEST RESULT: FAIL");
            $fatal(1, "store mismatch");
        end
    endtask

    task automatic report_unexpected(input string kind);
        $display("An unexpected %s event appeared after all expected ones", kind);
        $display("TEST RESULT: FAIL");
        $fatal(1, "unexpected event");
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout: not all expected events appeared within %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        void'($urandom(32'h6d1e));
        build_program();
        for (int i = 0; i < 64; i++) begin
            i_mem.rom[i] = (i < prog.size()) ? prog[i] : '0;
            ram_seed[i]  = $urandom;
            i_mem.ram[i] = ram_seed[i];
        end
        build_expected();
        cycle_limit = 8 + 3 * prog.size();

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        // Outputs are stable at the falling edge
        while (wb_seen < exp_wb_name.size() || st_seen < exp_st_name.size()) begin
            @(negedge clk);
            if (wb_we) begin
                if (wb_seen >= exp_wb_name.size()) begin
                    report_unexpected("write-back");
                end else begin
                    check_wb(exp_wb_name[wb_seen], exp_wb_pc[wb_seen],
                             exp_wb_regf[wb_seen], exp_wb_data[wb_seen],
                             wb_pc, wb_regf, wb_data);
                end
                wb_seen++;
            end
            if (dmem_we) begin
                if (st_seen >= exp_st_name.size()) begin
                    report_unexpected("store");
                end else begin
                    check_store(exp_st_name[st_seen], exp_st_addr[st_seen],
                                exp_st_data[st_seen], dmem_addr, dmem_wdata);
                end
                st_seen++;
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== test/tb_mem.sv ====
`timescale 1ns/1ns

module tb_mem import mips_pkg::*; (
    input  logic  clk_i,
    input  word_t imem_addr_i,
    output word_t imem_data_o,
    input  logic  dmem_we_i,
    input  word_t dmem_addr_i,
    input  word_t dmem_wdata_i,
    output word_t dmem_rdata_o
);

    word_t rom [64];
    word_t ram [64];
    word_t rdata_q = '0;

    // Fetches past the end of the ROM see NOPs
    assign imem_data_o = (imem_addr_i[31:8] == '0) ? rom[imem_addr_i[7:2]] : '0;

    always @(posedge clk_i) begin
        if (dmem_we_i) begin
            ram[dmem_addr_i[7:2]] <= dmem_wdata_i;
        end
        rdata_q <= ram[dmem_addr_i[7:2]];   // Synchronous read
    end

    assign dmem_rdata_o = rdata_q;

endmodule

// ==== logic/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top import mips_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  rst_n_i,
    output word_t imem_addr_o,
    input  word_t imem_data_i,
    output logic  dmem_we_o,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    input  word_t dmem_rdata_i,
    output logic  wb_we_o,
    output word_t wb_pc_o,
    output regf_t wb_regf_o,
    output word_t wb_data_o
);

    regf_if regf_ ();

    datapath #(
        .RESET_PC (RESET_PC)
    ) datapath_ (
        .clk          (clk          ),
        .rst_n_i      (rst_n_i      ),
        .imem_addr_o  (imem_addr_o  ),
        .imem_data_i  (imem_data_i  ),
        .dmem_we_o    (dmem_we_o    ),
        .dmem_addr_o  (dmem_addr_o  ),
        .dmem_wdata_o (dmem_wdata_o ),
        .dmem_rdata_i (dmem_rdata_i ),
        .wb_we_o      (wb_we_o      ),
        .wb_pc_o      (wb_pc_o      ),
        .wb_regf_o    (wb_regf_o    ),
        .wb_data_o    (wb_data_o    ),
        .regf         (regf_.master )
    );

    regfile regfile_ (
        .clk     (clk         ),
        .rst_n_i (rst_n_i     ),
        .regf    (regf_.slave )
    );

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ns

module datapath import mips_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic          clk,
    input  logic          rst_n_i,
    output word_t         imem_addr_o,      // IF
    input  word_t         imem_data_i,      // IF
    output logic          dmem_we_o,        // MM
    output word_t         dmem_addr_o,      // MM
    output word_t         dmem_wdata_o,     // MM
    input  word_t         dmem_rdata_i,     // WB
    output logic          wb_we_o,
    output word_t         wb_pc_o,
    output regf_t         wb_regf_o,
    output word_t         wb_data_o,
    regf_if.master        regf              // ID read, WB write
);

    word_t      pc_q;
    word_t      if_id_pc;
    inst_u      if_id_inst;
    id_ex_t     id_pkt;
    id_ex_t     id_ex_q;
    ex_mm_t     ex_pkt;
    ex_mm_t     ex_mm_q;
    mm_wb_t     mm_wb_q;

    logic       branch;
    word_t      branch_addr;
    word_t      ex_result;
    word_t      ex_store_data;
    word_t      wb_data;

    logic [1:0] fwd_id_rs_sel;
    logic [1:0] fwd_id_rt_sel;
    logic [1:0] fwd_ex_rs_sel;
    logic [1:0] fwd_ex_rt_sel;
    logic       pc_stall;
    logic       if_id_stall;
    logic       id_ex_flush;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!pc_stall) begin
            pc_q <= branch ? branch_addr : pc_q + 32'd4;   // Redirect after the delay slot
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            if_id_pc   <= '0;
            if_id_inst <= '0;
        end else if (!if_id_stall) begin
            if_id_pc   <= pc_q;
            if_id_inst <= imem_data_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_ex_q <= '0;
            ex_mm_q <= '0;
            mm_wb_q <= '0;
        end else begin
            id_ex_q <= id_ex_flush ? '0 : id_pkt;
            ex_mm_q <= ex_pkt;
            mm_wb_q <= '{pc: ex_mm_q.pc, oper: ex_mm_q.oper, rd: ex_mm_q.rd,
                         alu_result: ex_mm_q.alu_result};
        end
    end

    decoder decoder_ (
        .pc_i          (if_id_pc            ),
        .inst_i        (if_id_inst          ),
        .rs_data_i     (regf.rs_data        ),
        .rt_data_i     (regf.rt_data        ),
        .fwd_rs_sel_i  (fwd_id_rs_sel       ),
        .fwd_rt_sel_i  (fwd_id_rt_sel       ),
        .fwd_data_ex_i (ex_result           ),
        .fwd_data_mm_i (ex_mm_q.alu_result  ),
        .fwd_data_wb_i (wb_data             ),
        .id_ex_o       (id_pkt              ),
        .branch_o      (branch              ),
        .branch_addr_o (branch_addr         )
    );

    alu alu_ (
        .id_ex_i       (id_ex_q             ),
        .fwd_rs_sel_i  (fwd_ex_rs_sel       ),
        .fwd_rt_sel_i  (fwd_ex_rt_sel       ),
        .fwd_data_mm_i (ex_mm_q.alu_result  ),
        .fwd_data_wb_i (wb_data             ),
        .result_o      (ex_result           ),
        .store_data_o  (ex_store_data       )
    );

    hazard_unit hazard_unit_ (
        .id_oper_i       (id_pkt.oper  ),
        .id_rs_i         (id_pkt.rs    ),
        .id_rt_i         (id_pkt.rt    ),
        .ex_packet_i     (id_ex_q      ),
        .mm_packet_i     (ex_mm_q      ),
        .wb_packet_i     (mm_wb_q      ),
        .fwd_id_rs_sel_o (fwd_id_rs_sel),
        .fwd_id_rt_sel_o (fwd_id_rt_sel),
        .fwd_ex_rs_sel_o (fwd_ex_rs_sel),
        .fwd_ex_rt_sel_o (fwd_ex_rt_sel),
        .pc_stall_o      (pc_stall     ),
        .if_id_stall_o   (if_id_stall  ),
        .id_ex_flush_o   (id_ex_flush  )
    );

    assign ex_pkt = '{pc: id_ex_q.pc, oper: id_ex_q.oper, rd: id_ex_q.rd,
                      alu_result: ex_result, store_data: ex_store_data};

    assign imem_addr_o  = pc_q;
    assign dmem_we_o    = (ex_mm_q.oper == OPER_SW);
    assign dmem_addr_o  = ex_mm_q.alu_result;
    assign dmem_wdata_o = ex_mm_q.store_data;

    // Load data arrives one cycle after the MM address
    assign wb_data = (mm_wb_q.oper == OPER_LW) ? dmem_rdata_i : mm_wb_q.alu_result;

    assign regf.rs_regf = id_pkt.rs;
    assign regf.rt_regf = id_pkt.rt;
    assign regf.rd_we   = (mm_wb_q.rd != '0);
    assign regf.rd_regf = mm_wb_q.rd;
    assign regf.rd_data = wb_data;

    assign wb_we_o   = regf.rd_we;
    assign wb_pc_o   = mm_wb_q.pc;
    assign wb_regf_o = mm_wb_q.rd;
    assign wb_data_o = wb_data;

    a_store_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        dmem_we_o |-> dmem_addr_o[1:0] == 2'b00);

    a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_q[1:0] == 2'b00);

    // Load-use costs one bubble unless ID holds a branch
    a_one_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        pc_stall && id_pkt.oper != OPER_BEQ && id_pkt.oper != OPER_BNE |=> !pc_stall);

endmodule

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit import mips_pkg::*; (
    input  oper_e      id_oper_i,
    input  regf_t      id_rs_i,
    input  regf_t      id_rt_i,
    input  id_ex_t     ex_packet_i,
    input  ex_mm_t     mm_packet_i,
    input  mm_wb_t     wb_packet_i,
    output logic [1:0] fwd_id_rs_sel_o,
    output logic [1:0] fwd_id_rt_sel_o,
    output logic [1:0] fwd_ex_rs_sel_o,
    output logic [1:0] fwd_ex_rt_sel_o,
    output logic       pc_stall_o,
    output logic       if_id_stall_o,
    output logic       id_ex_flush_o
);

    logic id_branch;
    logic stall;

    assign id_branch = (id_oper_i == OPER_BEQ) || (id_oper_i == OPER_BNE);

    // Newest producer wins, a load only has data once it reaches WB
    function automatic logic [1:0] src_id(input regf_t src);
        if (src == '0) return FWD_NONE;
        if (ex_packet_i.rd == src) return (ex_packet_i.oper == OPER_LW) ? FWD_NONE : FWD_EX;
        if (mm_packet_i.rd == src) return (mm_packet_i.oper == OPER_LW) ? FWD_NONE : FWD_MM;
        if (wb_packet_i.rd == src) return FWD_WB;
        return FWD_NONE;
    endfunction

    function automatic logic [1:0] src_ex(input regf_t src);
        if (src == '0) return FWD_NONE;
        if (mm_packet_i.rd == src) return (mm_packet_i.oper == OPER_LW) ? FWD_NONE : FWD_MM;
        if (wb_packet_i.rd == src) return FWD_WB;
        return FWD_NONE;
    endfunction

    // Branches need operands in ID, everything else can pick up WB data in EX
    function automatic logic must_wait(input regf_t src);
        if (src == '0) return 1'b0;
        if (ex_packet_i.rd == src) return ex_packet_i.oper == OPER_LW;
        if (mm_packet_i.rd == src) return id_branch && mm_packet_i.oper == OPER_LW;
        return 1'b0;
    endfunction

    always_comb begin
        fwd_id_rs_sel_o = src_id(id_rs_i);
        fwd_id_rt_sel_o = src_id(id_rt_i);
        fwd_ex_rs_sel_o = src_ex(ex_packet_i.rs);
        fwd_ex_rt_sel_o = src_ex(ex_packet_i.rt);
        stall           = must_wait(id_rs_i) || must_wait(id_rt_i);
    end

    assign pc_stall_o    = stall;
    assign if_id_stall_o = stall;
    assign id_ex_flush_o = stall;   // Bubble into EX

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ns

module alu import mips_pkg::*; (
    input  id_ex_t     id_ex_i,
    input  logic [1:0] fwd_rs_sel_i,
    input  logic [1:0] fwd_rt_sel_i,
    input  word_t      fwd_data_mm_i,
    input  word_t      fwd_data_wb_i,
    output word_t      result_o,
    output word_t      store_data_o
);

    word_t a;
    word_t b;

    // EX only sees producers that moved on to MM or WB
    function automatic word_t fwd_pick(input logic [1:0] sel, input word_t reg_val);
        case (sel)
            FWD_MM:  return fwd_data_mm_i;
            FWD_WB:  return fwd_data_wb_i;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        a = fwd_pick(fwd_rs_sel_i, id_ex_i.rs_data);
        b = fwd_pick(fwd_rt_sel_i, id_ex_i.rt_data);
        case (id_ex_i.oper)
            OPER_ADDU:                    result_o = a + b;
            OPER_SUBU:                    result_o = a - b;
            OPER_AND:                     result_o = a & b;
            OPER_OR:                      result_o = a | b;
            OPER_SLT:                     result_o = {31'd0, $signed(a) < $signed(b)};
            OPER_ADDIU, OPER_LW, OPER_SW: result_o = a + id_ex_i.imm;
            OPER_ORI:                     result_o = a | id_ex_i.imm;
            OPER_LUI:                     result_o = id_ex_i.imm;   // Already shifted in ID
            default:                      result_o = '0;
        endcase
    end

    assign store_data_o = b;

endmodule

// ==== logic/decoder.sv ====
`timescale 1ns/1ns

module decoder import mips_pkg::*; (
    input  word_t      pc_i,
    input  inst_u      inst_i,
    input  word_t      rs_data_i,
    input  word_t      rt_data_i,
    input  logic [1:0] fwd_rs_sel_i,
    input  logic [1:0] fwd_rt_sel_i,
    input  word_t      fwd_data_ex_i,
    input  word_t      fwd_data_mm_i,
    input  word_t      fwd_data_wb_i,
    output id_ex_t     id_ex_o,
    output logic       branch_o,
    output word_t      branch_addr_o
);

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    oper_e oper;
    regf_t rd;
    word_t imm;
    logic  use_rs;
    logic  use_rt;
    word_t rs_val;
    word_t rt_val;

    function automatic word_t fwd_pick(input logic [1:0] sel, input word_t reg_val);
        case (sel)
            FWD_EX:  return fwd_data_ex_i;
            FWD_MM:  return fwd_data_mm_i;
            FWD_WB:  return fwd_data_wb_i;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        oper   = OPER_NOP;
        rd     = '0;
        use_rs = 1'b0;
        use_rt = 1'b0;
        imm    = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
        case (inst_i.i.opcode)
            OP_SPECIAL: begin
                case (inst_i.r.funct)
                    FN_ADDU: oper = OPER_ADDU;
                    FN_SUBU: oper = OPER_SUBU;
                    FN_AND:  oper = OPER_AND;
                    FN_OR:   oper = OPER_OR;
                    FN_SLT:  oper = OPER_SLT;
                    default: oper = OPER_NOP;       // SLL and the rest
                endcase
                use_rs = (oper != OPER_NOP);
                use_rt = (oper != OPER_NOP);
                rd     = (oper != OPER_NOP) ? inst_i.r.rd : regf_t'(0);
            end
            OP_ADDIU, OP_LW: begin
                oper   = (inst_i.i.opcode == OP_LW) ? OPER_LW : OPER_ADDIU;
                use_rs = 1'b1;
                rd     = inst_i.i.rt;
            end
            OP_ORI: begin
                oper   = OPER_ORI;
                use_rs = 1'b1;
                rd     = inst_i.i.rt;
                imm    = {16'h0, inst_i.i.imm};     // Zero extended
            end
            OP_LUI: begin
                oper = OPER_LUI;
                rd   = inst_i.i.rt;
                imm  = {inst_i.i.imm, 16'h0};
            end
            OP_SW, OP_BEQ, OP_BNE: begin
                oper   = (inst_i.i.opcode == OP_SW)  ? OPER_SW  :
                         (inst_i.i.opcode == OP_BEQ) ? OPER_BEQ : OPER_BNE;
                use_rs = 1'b1;
                use_rt = 1'b1;
            end
            default: oper = OPER_NOP;
        endcase
    end

    always_comb begin
        rs_val = fwd_pick(fwd_rs_sel_i, rs_data_i);
        rt_val = fwd_pick(fwd_rt_sel_i, rt_data_i);
    end

    assign branch_o = (oper == OPER_BEQ && rs_val == rt_val) ||
                      (oper == OPER_BNE && rs_val != rt_val);
    assign branch_addr_o = pc_i + 32'd4 + {imm[29:0], 2'b00};

    assign id_ex_o = '{
        pc:      pc_i,
        oper:    oper,
        rs:      use_rs ? inst_i.i.rs : regf_t'(0),
        rt:      use_rt ? inst_i.i.rt : regf_t'(0),
        rd:      rd,
        rs_data: rs_val,
        rt_data: rt_val,
        imm:     imm
    };

endmodule

// ==== logic/regfile.sv ====
`timescale 1ns/1ns

module regfile import mips_pkg::*; (
    input logic   clk,
    input logic   rst_n_i,
    regf_if.slave regf
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regf.rd_we && regf.rd_regf != '0) begin
            regs[regf.rd_regf] <= regf.rd_data;     // $0 never written
        end
    end

    // Same-cycle write is not bypassed here, WB forwarding covers it
    assign regf.rs_data = (regf.rs_regf == '0) ? '0 : regs[regf.rs_regf];
    assign regf.rt_data = (regf.rt_regf == '0) ? '0 : regs[regf.rt_regf];

endmodule

// ==== logic/regf_if.sv ====
`timescale 1ns/1ns

interface regf_if import mips_pkg::*; ();
    regf_t rs_regf;
    word_t rs_data;
    regf_t rt_regf;
    word_t rt_data;
    logic  rd_we;
    regf_t rd_regf;
    word_t rd_data;

    modport master (
        output rs_regf, rt_regf, rd_we, rd_regf, rd_data,
        input  rs_data, rt_data
    );

    modport slave (
        input  rs_regf, rt_regf, rd_we, rd_regf, rd_data,
        output rs_data, rt_data
    );
endinterface

// ==== logic/mips_pkg.sv ====
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regf_t;

    typedef enum logic [3:0] {
        OPER_NOP = 4'd0,    // Zero so a cleared packet is a bubble
        OPER_ADDU,
        OPER_SUBU,
        OPER_AND,
        OPER_OR,
        OPER_SLT,
        OPER_ADDIU,
        OPER_ORI,
        OPER_LUI,
        OPER_LW,
        OPER_SW,
        OPER_BEQ,
        OPER_BNE
    } oper_e;

    typedef struct packed {
        logic [5:0] opcode;
        regf_t      rs;
        regf_t      rt;
        regf_t      rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        regf_t       rs;
        regf_t       rt;
        logic [15:0] imm;
    } i_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } inst_u;

    // Forwarding source select
    localparam logic [1:0] FWD_NONE = 2'd0;
    localparam logic [1:0] FWD_EX   = 2'd1;
    localparam logic [1:0] FWD_MM   = 2'd2;
    localparam logic [1:0] FWD_WB   = 2'd3;

    typedef struct packed {
        word_t pc;
        oper_e oper;
        regf_t rs;          // Zero when not read
        regf_t rt;
        regf_t rd;          // Zero when nothing is written
        word_t rs_data;
        word_t rt_data;
        word_t imm;
    } id_ex_t;

    typedef struct packed {
        word_t pc;
        oper_e oper;
        regf_t rd;
        word_t alu_result;  // Also the LW/SW address
        word_t store_data;
    } ex_mm_t;

    typedef struct packed {
        word_t pc;
        oper_e oper;
        regf_t rd;
        word_t alu_result;
    } mm_wb_t;

endpackage
